/* inst_fetch_pkg.sv */
// Instruction fetch definitions
package inst_fetch_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;

    // Address map
    localparam logic [7:0]  ram_region  = 8'h00;   // bits 31..24
    localparam logic [11:0] boot_prefix = 12'h1fc; // bits 31..20

    // Boot ROM contents, word indexed by address bits 4..2
    localparam int boot_depth = 8;
    localparam logic [data_w-1:0] boot_table [0:boot_depth-1] = '{
        32'h3c08_bfc0,  // lui   t0, 0xbfc0
        32'h2508_0100,  // addiu t0, t0, 0x100
        32'h3c09_0000,  // lui   t1, 0
        32'h2529_0100,  // addiu t1, t1, 0x100
        32'h8d0a_0000,  // lw    t2, 0(t0)
        32'had2a_0000,  // sw    t2, 0(t1)
        32'h1000_ffff,  // b     .
        32'h0000_0000   // nop
    };

    // Boot ROM wait states
    localparam int boot_wait_cycles = 2;
    localparam int boot_cnt_w = $clog2(boot_wait_cycles + 1);

    // Decode stage credits
    localparam int num_credits = 4;
    localparam int credit_w = 3;

    // Fetch FSM encoding
    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_request = 2'd1;
    localparam logic [1:0] st_error   = 2'd2;

    // One fetch address, seen as SRAM or as boot ROM
    typedef union packed {
        struct packed {
            logic [7:0]  region;
            logic [23:0] offset;
        } ram_view;
        struct packed {
            logic [11:0] prefix;
            logic [19:0] offset;
        } boot_view;
    } inst_addr_u;

endpackage

/* inst_bus_if.sv */
// Internal instruction bus
interface inst_bus_if;
    import inst_fetch_pkg::*;

    // Request side, held until a cycle without stall
    logic [addr_w-1:0] addr;
    logic              read;

    // Response side
    logic [data_w-1:0] rdata;  // Valid when read high and stall low
    logic              stall;
    logic              error;  // Unmapped address

    modport master (
        output addr,
        output read,
        input  rdata,
        input  stall,
        input  error
    );

    modport slave (
        input  addr,
        input  read,
        output rdata,
        output stall,
        output error
    );

endinterface

/* boot_wait_timer.sv */
// Boot ROM wait state timer
module boot_wait_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic busy
);
    import inst_fetch_pkg::*;

    logic [boot_cnt_w-1:0] count;

    // Busy in the start cycle, then one cycle per wait state
    assign busy = start || (count != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (start && count == '0) begin
            count <= boot_cnt_w'(boot_wait_cycles);
        end else if (count != '0) begin
            count <= count - 1'b1;  // Start while busy falls through here
        end
    end

endmodule

/* fetch_ctrl.sv */
// Instruction fetch controller
module fetch_ctrl (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              run,
    input  logic [inst_fetch_pkg::addr_w-1:0] start_pc,
    input  logic                              credit_return,
    inst_bus_if.master                        bus,
    output logic                              inst_valid,
    output logic [inst_fetch_pkg::data_w-1:0] inst_data,
    output logic [inst_fetch_pkg::addr_w-1:0] inst_pc,
    output logic                              bus_error
);
    import inst_fetch_pkg::*;

    logic [1:0]          state;
    logic                run_q;
    logic [addr_w-1:0]   pc;
    logic [credit_w-1:0] credit_cnt;
    logic                run_rise;
    logic                credit_ok;
    logic                fetch_ok;
    logic                bus_done;

    assign run_rise = run && !run_q;

    // A word leaving this cycle still holds its credit
    assign credit_ok = credit_cnt > credit_w'(inst_valid);
    assign fetch_ok  = run && (state == st_idle) && credit_ok;
    assign bus_done  = bus.read && !bus.stall;

    assign bus.addr  = pc;
    assign bus.read  = (state == st_request);
    assign bus_error = (state == st_error);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_idle;
            run_q      <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            run_q      <= run;
            inst_valid <= 1'b0;  // Single cycle pulse
            case (state)
                st_idle: begin
                    if (fetch_ok)
                        state <= st_request;
                end
                st_request: begin
                    if (bus_done && bus.error) begin
                        state <= st_error;
                    end else if (bus_done) begin
                        inst_valid <= 1'b1;
                        state      <= st_idle;
                    end
                end
                st_error: begin
                    if (!run)
                        state <= st_idle;  // Cleared only by dropping run
                end
                default: state <= st_idle;
            endcase
        end
    end

    // PC and output word
    always_ff @(posedge clk) begin
        if (state == st_idle && run_rise)
            pc <= start_pc;
        else if (state == st_request && bus_done && !bus.error)
            pc <= pc + addr_w'(4);
        if (state == st_request && bus_done) begin
            inst_data <= bus.rdata;
            inst_pc   <= pc;
        end
    end

    // Credits back from decode, spent on each word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt <= credit_w'(num_credits);
        end else begin
            case ({credit_return, inst_valid})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;  // Both or neither
            endcase
        end
    end

endmodule

/* inst_bus.sv */
// Instruction bus decoder
module inst_bus (
    input  logic                              clk,
    input  logic                              rst_n,
    inst_bus_if.slave                         bus,
    output logic [23:0]                       ram_addr,
    output logic                              ram_read_enable,
    input  logic [inst_fetch_pkg::data_w-1:0] ram_rdata,
    input  logic                              ram_stall
);
    import inst_fetch_pkg::*;

    localparam int boot_idx_w = $clog2(boot_depth);

    inst_addr_u          req_addr;
    logic                ram_sel;
    logic                boot_sel;
    logic                req_active;
    logic                boot_start;
    logic                boot_busy;
    logic [data_w-1:0]   boot_q;
    logic [boot_idx_w-1:0] boot_idx;

    // Same word, two decodings
    assign req_addr = bus.addr;
    assign ram_sel  = (req_addr.ram_view.region == ram_region);
    assign boot_sel = (req_addr.boot_view.prefix == boot_prefix);
    assign boot_idx = req_addr.boot_view.offset[boot_idx_w+1:2];

    // SRAM port
    assign ram_addr        = req_addr.ram_view.offset;
    assign ram_read_enable = ram_sel && bus.read;

    // Set while a request sits stalled
    always_ff @(posedge clk) begin
        if (!rst_n)
            req_active <= 1'b0;
        else
            req_active <= bus.read && bus.stall;
    end

    assign boot_start = boot_sel && bus.read && !req_active;  // First cycle only

    boot_wait_timer i_boot_wait_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .start (boot_start),
        .busy  (boot_busy)
    );

    // Boot ROM read register, settles during the wait states
    always_ff @(posedge clk) begin
        if (boot_sel && bus.read)
            boot_q <= boot_table[boot_idx];
    end

    always_comb begin
        bus.stall = 1'b0;
        bus.error = 1'b0;
        if (bus.read) begin
            if (ram_sel)
                bus.stall = ram_stall;
            else if (boot_sel)
                bus.stall = boot_busy;
            else
                bus.error = 1'b1;  // Unmapped, answered at once
        end
    end

    assign bus.rdata = ram_sel ? ram_rdata : boot_q;

endmodule

/* inst_fetch_top.sv */
// Instruction fetch top level
module inst_fetch_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              run,
    input  logic [inst_fetch_pkg::addr_w-1:0] start_pc,
    input  logic                              credit_return,
    input  logic [inst_fetch_pkg::data_w-1:0] ram_rdata,
    input  logic                              ram_stall,
    output logic                              inst_valid,
    output logic [inst_fetch_pkg::data_w-1:0] inst_data,
    output logic [inst_fetch_pkg::addr_w-1:0] inst_pc,
    output logic                              bus_error,
    output logic [23:0]                       ram_addr,
    output logic                              ram_read_enable
);

    // Fetch to bus link
    inst_bus_if bus_if ();

    fetch_ctrl i_fetch_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .run           (run),
        .start_pc      (start_pc),
        .credit_return (credit_return),
        .bus           (bus_if.master),
        .inst_valid    (inst_valid),
        .inst_data     (inst_data),
        .inst_pc       (inst_pc),
        .bus_error     (bus_error)
    );

    // Decodes to SRAM or boot ROM
    inst_bus i_inst_bus (
        .clk             (clk),
        .rst_n           (rst_n),
        .bus             (bus_if.slave),
        .ram_addr        (ram_addr),
        .ram_read_enable (ram_read_enable),
        .ram_rdata       (ram_rdata),
        .ram_stall       (ram_stall)
    );

endmodule

/* inst_fetch_props.sv */
// Instruction fetch properties
module inst_fetch_props (
    input logic                              clk,
    input logic                              rst_n,
    input logic                              run,
    input logic [inst_fetch_pkg::addr_w-1:0] start_pc,
    input logic                              credit_return,
    input logic                              ram_stall,
    input logic                              inst_valid,
    input logic [inst_fetch_pkg::data_w-1:0] inst_data,
    input logic [inst_fetch_pkg::addr_w-1:0] inst_pc,
    input logic                              bus_error,
    input logic [23:0]                       ram_addr,
    input logic                              ram_read_enable,
    input logic                              bus_read,
    input logic [inst_fetch_pkg::addr_w-1:0] bus_addr
);
    import inst_fetch_pkg::*;

    int                fail_count = 0;
    logic              run_seen;
    logic              run_q;
    logic [addr_w-1:0] exp_pc;       // PC the next word should carry
    int                outstanding;  // Words sent minus credits back
    logic              boot_req;
    logic              unmapped_req;

    assign boot_req     = bus_addr[31:20] == boot_prefix;
    assign unmapped_req = bus_addr[31:24] != ram_region && !boot_req;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_seen    <= 1'b0;
            run_q       <= 1'b0;
            outstanding <= 0;
        end else begin
            run_q <= run;
            if (run)
                run_seen <= 1'b1;
            if (run && !run_q)
                exp_pc <= start_pc;  // Sequence restarts on run
            else if (inst_valid)
                exp_pc <= exp_pc + 32'd4;
            outstanding <= outstanding + int'(inst_valid) - int'(credit_return);
        end
    end

    quiet_after_reset: assert property (@(posedge clk)
        rst_n && !run_seen |-> !inst_valid && !ram_read_enable && !bus_error)
        else begin fail_count++; $error("Output active before run"); end

    boot_word: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid && exp_pc[31:20] == boot_prefix |->
            inst_data == boot_table[exp_pc[4:2]])
        else begin fail_count++; $error("Boot word mismatch"); end

    pc_step: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid |-> inst_pc == exp_pc)
        else begin fail_count++; $error("Word carries the wrong PC"); end

    // Stall covers the start cycle and the wait states, the word follows
    boot_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(bus_read) && boot_req |=>
            !inst_valid [*boot_wait_cycles + 1] ##1 inst_valid)
        else begin fail_count++; $error("Boot access latency wrong"); end

    ram_word: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid && exp_pc[31:24] == ram_region |->
            inst_data == (exp_pc ^ 32'h5a5a_0000))
        else begin fail_count++; $error("SRAM word mismatch"); end

    ram_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ram_read_enable && ram_stall |=> $stable(ram_addr) && !inst_valid)
        else begin fail_count++; $error("Stalled SRAM request moved"); end

    credit_spend: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid |-> outstanding < num_credits)
        else begin fail_count++; $error("Word sent without credit"); end

    credit_block: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding >= num_credits |-> !ram_read_enable)
        else begin fail_count++; $error("SRAM read without credit"); end

    error_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(bus_read) && unmapped_req |=> bus_error)
        else begin fail_count++; $error("Unmapped read gave no error"); end

    error_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        bus_error |-> !inst_valid && !ram_read_enable)
        else begin fail_count++; $error("Activity during bus error"); end

    error_clear: assert property (@(posedge clk) disable iff (!rst_n)
        bus_error && !run |=> !bus_error)
        else begin fail_count++; $error("Bus error held after run low"); end

endmodule

bind inst_fetch_top inst_fetch_props i_props (
    .clk             (clk),
    .rst_n           (rst_n),
    .run             (run),
    .start_pc        (start_pc),
    .credit_return   (credit_return),
    .ram_stall       (ram_stall),
    .inst_valid      (inst_valid),
    .inst_data       (inst_data),
    .inst_pc         (inst_pc),
    .bus_error       (bus_error),
    .ram_addr        (ram_addr),
    .ram_read_enable (ram_read_enable),
    .bus_read        (bus_if.read),
    .bus_addr        (bus_if.addr)
);

/* tb_inst_fetch.sv */
// Instruction fetch testbench
module tb_inst_fetch;
    import inst_fetch_pkg::*;

    localparam int test_cycles = 300;  // Upper bound per test
    localparam int num_tests   = 5;
    localparam int watchdog_time = (num_tests * test_cycles + 200) * 4;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              run;
    logic [31:0]       start_pc;
    logic              credit_return;
    logic [31:0]       ram_rdata;
    logic              ram_stall;
    logic              inst_valid;
    logic [31:0]       inst_data;
    logic [31:0]       inst_pc;
    logic              bus_error;
    logic [23:0]       ram_addr;
    logic              ram_read_enable;

    logic [31:0] lfsr_state = 32'hcb49;
    logic        stall_en;
    logic        immediate;    // Credit return mode
    logic        extra_credit;
    int          valid_count;
    int          extra_errors;
    int          fails_before = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    inst_fetch_top i_inst_fetch_top (.*);

    always #2 clk = ~clk;

    // SRAM model, data is combinational
    assign ram_rdata = {8'h00, ram_addr} ^ 32'h5a5a_0000;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    always @(negedge clk) begin
        if (stall_en) begin
            ram_stall  = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);  // One step per bit taken
        end else begin
            ram_stall = 1'b0;
        end
        credit_return = (immediate && inst_valid) || extra_credit;
        extra_credit  = 1'b0;
    end

    always @(posedge clk) begin
        if (!rst_n)
            valid_count <= 0;
        else if (inst_valid)
            valid_count <= valid_count + 1;
    end

    task automatic apply_reset();
        rst_n = 1'b0;
        run   = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        extra_errors = 0;
    endtask

    task automatic wait_valids(input int n);
        int i;
        for (i = 0; i < test_cycles && valid_count < n; i++)
            @(negedge clk);
        if (valid_count < n) begin
            $display("Timed out waiting for %0d words, saw %0d", n, valid_count);
            extra_errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected);
        if (valid_count != expected) begin
            $display("Fail %s: expected %0d words, actual %0d", name, expected,
                     valid_count);
            extra_errors++;
        end
    endtask

    task automatic end_test(input string name);
        int fails;
        run = 1'b0;
        repeat (3) @(negedge clk);
        fails = i_inst_fetch_top.i_props.fail_count - fails_before;
        fails_before = i_inst_fetch_top.i_props.fail_count;
        if (fails == 0 && extra_errors == 0) begin
            $display("Pass %s", name);
            tests_passed++;
        end else begin
            $display("Fail %s: expected 0 failures, actual %0d", name, fails + extra_errors);
            tests_failed++;
        end
    endtask

    initial begin
        run           = 1'b0;
        start_pc      = '0;
        credit_return = 1'b0;
        ram_stall     = 1'b0;
        stall_en      = 1'b0;
        immediate     = 1'b1;
        extra_credit  = 1'b0;
        apply_reset();
        repeat (10) @(negedge clk);
        end_test("reset_state");

        apply_reset();
        start_pc = 32'h1fc0_0000;
        run = 1'b1;
        wait_valids(boot_depth);
        end_test("boot_fetch");

        apply_reset();
        stall_en = 1'b1;
        start_pc = 32'h0000_0100;
        run = 1'b1;
        wait_valids(16);
        stall_en = 1'b0;
        end_test("sram_stall");

        apply_reset();
        immediate = 1'b0;
        start_pc = 32'h0000_0200;
        run = 1'b1;
        wait_valids(num_credits);
        repeat (20) @(negedge clk);
        check_count("credit_limit", num_credits);
        extra_credit = 1'b1;
        repeat (20) @(negedge clk);
        check_count("credit_limit", num_credits + 1);
        immediate = 1'b1;
        end_test("credit_limit");

        apply_reset();
        start_pc = 32'h4000_0000;
        run = 1'b1;
        repeat (10) @(negedge clk);
        if (!bus_error) begin
            $display("Bus error did not rise for an unmapped address");
            extra_errors++;
        end
        run = 1'b0;
        repeat (3) @(negedge clk);
        end_test("unmapped");

        $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        #(watchdog_time);
        $display("Watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* compile.f */
inst_fetch_pkg.sv
inst_bus_if.sv
boot_wait_timer.sv
fetch_ctrl.sv
inst_bus.sv
inst_fetch_top.sv
inst_fetch_props.sv
tb_inst_fetch.sv

/* Makefile */
# Verilator build and run for the instruction fetch testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -Wno-fatal
TOP       := tb_inst_fetch
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(wildcard *.sv)
RUN_ARGS  := +verilator+error+limit+1000

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) $(RUN_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(OBJ_DIR)
